// ==== include/synFilt_consts.svh ====
`ifndef SYN_FILT_CONSTS_SVH
`define SYN_FILT_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// filter geometry
////////////////////////////////////////////////////////////////////////////

`define SYN_FILT_L 40 // samples per subframe
`define SYN_FILT_M 10 // lpc order

////////////////////////////////////////////////////////////////////////////
// memory
////////////////////////////////////////////////////////////////////////////

`define ADDR_W 12
`define DATA_W 32

// 64 words of scratch, past outputs then new outputs
`define SYN_FILT_TEMP 12'hF00

////////////////////////////////////////////////////////////////////////////
// output scaling
////////////////////////////////////////////////////////////////////////////

`define SYN_FILT_SHIFT 3 // left shift before rounding
`define ROUND_CONST 32'h00008000 // half lsb of the upper word

`endif

// ==== verilog/basicOpPkg.sv ====
package basicOpPkg;

	// shifter sequencing
	typedef enum logic [1:0]
	{
		shlIdle,
		shlRun,
		shlFinish
	} shlState;

	// operation requested by the controller this cycle
	typedef enum logic [2:0]
	{
		opNone,
		opAdd,  // L_add
		opMult, // L_mult
		opMsu,  // L_msu, opC - a*b
		opShl   // start the iterative shifter
	} basicOpcode;

endpackage

// ==== verilog/synFiltPkg.sv ====
package synFiltPkg;

	typedef enum logic [4:0]
	{
		stInit,
		stMemCopyAddr,  // filter memory into scratch
		stMemCopyWrite,
		stOuterAddr,    // per sample
		stLoadX,
		stFirstProduct,
		stInnerAddr,    // per coefficient
		stInnerLoadA,
		stInnerMsu,
		stShlStart,
		stShlWait,
		stRound,
		stNextSample,
		stCopyAddr,     // scratch out to y
		stCopyWrite,
		stUpdateCheck,  // optional memory update
		stUpdateAddr,
		stUpdateWrite
	} synFiltState;

endpackage

// ==== verilog/basicOps.sv ====
`timescale 1ns/10ps
`include "synFilt_consts.svh"

module basicOps import basicOpPkg::*;
(
	input logic clk,
	input logic reset,
	input basicOpcode op,
	input logic [`DATA_W-1:0] opA,
	input logic [`DATA_W-1:0] opB,
	input logic [`DATA_W-1:0] opC,
	input logic [`DATA_W-1:0] shlValue,
	input logic [15:0] shlAmount,
	input logic shlReady,
	output logic [`DATA_W-1:0] opResult,
	output logic [`DATA_W-1:0] shlResult,
	output logic shlDone
);

	shlState shifterState;
	logic [`DATA_W-1:0] shiftReg;
	logic [15:0] shiftCount;
	logic [`DATA_W-1:0] shiftedOnce;
	logic shlLoad;

	////////////////////////////////////////////////////////////////////////////
	// saturating arithmetic
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] satAdd(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] sum;
		sum = a + b;
		if ((a[31] == b[31]) && (sum[31] != a[31]))
			satAdd = a[31] ? 32'h80000000 : 32'h7FFFFFFF;
		else
			satAdd = sum;
	endfunction

	function automatic logic [31:0] satSub(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] diff;
		diff = a - b;
		if ((a[31] != b[31]) && (diff[31] != a[31])) // overflow flips the sign of a
			satSub = a[31] ? 32'h80000000 : 32'h7FFFFFFF;
		else
			satSub = diff;
	endfunction

	function automatic logic [31:0] lMult(input logic [15:0] a, input logic [15:0] b);
		logic signed [31:0] prod;
		prod = $signed(a) * $signed(b);
		if (prod == 32'sh40000000) // only -1 * -1 overflows
			lMult = 32'h7FFFFFFF;
		else
			lMult = {prod[30:0], 1'b0};
	endfunction

	always_comb
	begin
		case (op)
			opAdd: opResult = satAdd(opA, opB);
			opMult: opResult = lMult(opA[15:0], opB[15:0]);
			opMsu: opResult = satSub(opC, lMult(opA[15:0], opB[15:0]));
			default: opResult = '0; // shift result arrives on shlResult
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// one bit per cycle left shifter
	////////////////////////////////////////////////////////////////////////////

	assign shlLoad = shlReady && (op == opShl) && (shifterState == shlIdle);

	// sticks at the rail once saturated
	assign shiftedOnce = (shiftReg[31] != shiftReg[30]) ?
		(shiftReg[31] ? 32'h80000000 : 32'h7FFFFFFF) : {shiftReg[30:0], 1'b0};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			shifterState <= shlIdle;
			shiftCount <= '0;
		end
		else
		begin
			case (shifterState)
				shlIdle:
				begin
					if (shlLoad)
					begin
						shiftCount <= shlAmount;
						shifterState <= (shlAmount == 16'd0) ? shlFinish : shlRun;
					end
				end
				shlRun:
				begin
					shiftCount <= shiftCount - 16'd1;
					if (shiftCount == 16'd1)
						shifterState <= shlFinish;
				end
				default: shifterState <= shlIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (shlLoad)
			shiftReg <= shlValue;
		else if (shifterState == shlRun)
			shiftReg <= shiftedOnce;
	end

	assign shlResult = shiftReg;
	assign shlDone = (shifterState == shlFinish);

	// a request the shifter cannot take would be lost
	assert property (@(posedge clk) disable iff (reset)
		shlReady |-> (op == opShl) && (shifterState == shlIdle))
		else $error("shlReady while the shifter is busy or op is not opShl");

endmodule

// ==== verilog/scratchMemory.sv ====
`timescale 1ns/10ps
`include "synFilt_consts.svh"

module scratchMemory
(
	input logic clk,
	input logic busy,
	input logic [`ADDR_W-1:0] memAddr,
	input logic memWriteEn,
	input logic [`DATA_W-1:0] memData,
	input logic hostWriteEn,
	input logic [`ADDR_W-1:0] hostAddr,
	input logic [`DATA_W-1:0] hostData,
	output logic [`DATA_W-1:0] memReadData,
	output logic [`DATA_W-1:0] hostReadData
);

	logic [`DATA_W-1:0] mem [0:(1 << `ADDR_W)-1];
	logic [`DATA_W-1:0] readData;
	logic [`ADDR_W-1:0] addr;
	logic writeEn;
	logic [`DATA_W-1:0] writeData;

	////////////////////////////////////////////////////////////////////////////
	// port select, filter owns the array for a whole pass
	////////////////////////////////////////////////////////////////////////////

	assign addr = busy ? memAddr : hostAddr;
	assign writeEn = busy ? memWriteEn : hostWriteEn; // host writes dropped while busy
	assign writeData = busy ? memData : hostData;

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[addr] <= writeData;
		readData <= mem[addr]; // old data on collision
	end

	// one read register, whoever addressed it last cycle
	assign memReadData = readData;
	assign hostReadData = readData;

endmodule

// ==== verilog/synFilt.sv ====
`timescale 1ns/10ps
`include "synFilt_consts.svh"

module synFilt import basicOpPkg::*, synFiltPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`ADDR_W-1:0] xAddr,
	input logic [`ADDR_W-1:0] aAddr,
	input logic [`ADDR_W-1:0] yAddr,
	input logic [`ADDR_W-1:0] fMemAddr,
	input logic [`ADDR_W-1:0] updateAddr,
	input logic [`DATA_W-1:0] memReadData,
	input logic [`DATA_W-1:0] opResult,
	input logic [`DATA_W-1:0] shlResult,
	input logic shlDone,
	output logic done,
	output logic busy,
	output logic [`ADDR_W-1:0] memAddr,
	output logic memWriteEn,
	output logic [`DATA_W-1:0] memData,
	output basicOpcode op,
	output logic [`DATA_W-1:0] opA,
	output logic [`DATA_W-1:0] opB,
	output logic [`DATA_W-1:0] opC,
	output logic [`DATA_W-1:0] shlValue,
	output logic [15:0] shlAmount,
	output logic shlReady
);

	localparam logic [`ADDR_W-1:0] tempAddr = `SYN_FILT_TEMP;

	synFiltState state, nextState;
	logic [5:0] count1, nextCount1; // sample index
	logic [5:0] count2, nextCount2; // coefficient index
	logic [31:0] tempS, nextTempS;  // accumulator
	logic [15:0] tempX, nextTempX;
	logic [15:0] tempA, nextTempA;
	logic nextDone;

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stInit;
			count1 <= '0;
			count2 <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			count1 <= nextCount1;
			count2 <= nextCount2;
			done <= nextDone;
		end
	end

	always_ff @(posedge clk)
	begin
		tempS <= nextTempS;
		tempX <= nextTempX;
		tempA <= nextTempA;
	end

	assign busy = (state != stInit);

	////////////////////////////////////////////////////////////////////////////
	// sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextCount1 = count1;
		nextCount2 = count2;
		nextTempS = tempS;
		nextTempX = tempX;
		nextTempA = tempA;
		nextDone = 1'b0;
		memAddr = '0;
		memWriteEn = 1'b0;
		memData = '0;
		op = opNone;
		opA = '0;
		opB = '0;
		opC = '0;
		shlValue = '0;
		shlAmount = '0;
		shlReady = 1'b0;
		case (state)
			stInit:
			begin
				nextCount1 = '0;
				nextCount2 = '0;
				if (start)
					nextState = stMemCopyAddr;
			end
			stMemCopyAddr:
			begin
				if (count1 >= `SYN_FILT_M)
				begin
					nextCount1 = '0;
					nextState = stOuterAddr;
				end
				else
				begin
					memAddr = {fMemAddr[11:6], count1};
					nextState = stMemCopyWrite;
				end
			end
			stMemCopyWrite:
			begin
				memAddr = {tempAddr[11:6], count1};
				memWriteEn = 1'b1;
				memData = {16'd0, memReadData[15:0]};
				op = opAdd;
				opA = {26'd0, count1};
				opB = 32'd1;
				nextCount1 = opResult[5:0];
				nextState = stMemCopyAddr;
			end
			stOuterAddr:
			begin
				if (count1 >= `SYN_FILT_L)
				begin
					nextCount1 = '0;
					nextState = stCopyAddr;
				end
				else
				begin
					memAddr = {xAddr[11:6], count1};
					nextState = stLoadX;
				end
			end
			stLoadX:
			begin
				nextTempX = memReadData[15:0];
				memAddr = {aAddr[11:6], 6'd0}; // a0
				nextState = stFirstProduct;
			end
			stFirstProduct:
			begin
				op = opMult;
				opA = {16'd0, tempX};
				opB = {16'd0, memReadData[15:0]};
				nextTempS = opResult;
				nextCount2 = 6'd1;
				nextState = stInnerAddr;
			end
			stInnerAddr:
			begin
				if (count2 > `SYN_FILT_M)
					nextState = stShlStart;
				else
				begin
					memAddr = {aAddr[11:6], count2};
					nextState = stInnerLoadA;
				end
			end
			stInnerLoadA:
			begin
				nextTempA = memReadData[15:0];
				memAddr = {tempAddr[11:6], 6'(`SYN_FILT_M) - count2 + count1}; // y[i-j]
				op = opAdd; // adder is free here, msu needs the unit next
				opA = {26'd0, count2};
				opB = 32'd1;
				nextCount2 = opResult[5:0];
				nextState = stInnerMsu;
			end
			stInnerMsu:
			begin
				op = opMsu;
				opA = {16'd0, tempA};
				opB = {16'd0, memReadData[15:0]};
				opC = tempS;
				nextTempS = opResult;
				nextState = stInnerAddr;
			end
			stShlStart:
			begin
				op = opShl;
				shlValue = tempS;
				shlAmount = 16'(`SYN_FILT_SHIFT);
				shlReady = 1'b1;
				nextState = stShlWait;
			end
			stShlWait:
			begin
				if (shlDone)
				begin
					nextTempS = shlResult;
					nextState = stRound;
				end
			end
			stRound:
			begin
				op = opAdd;
				opA = tempS;
				opB = `ROUND_CONST;
				memAddr = {tempAddr[11:6], 6'(`SYN_FILT_M) + count1};
				memWriteEn = 1'b1;
				memData = {16'd0, opResult[31:16]}; // round() keeps the high half
				nextState = stNextSample;
			end
			stNextSample:
			begin
				op = opAdd;
				opA = {26'd0, count1};
				opB = 32'd1;
				nextCount1 = opResult[5:0];
				nextState = stOuterAddr;
			end
			stCopyAddr:
			begin
				if (count1 >= `SYN_FILT_L)
				begin
					memAddr = updateAddr; // flag word ready next cycle
					nextCount1 = '0;
					nextState = stUpdateCheck;
				end
				else
				begin
					memAddr = {tempAddr[11:6], 6'(`SYN_FILT_M) + count1};
					nextState = stCopyWrite;
				end
			end
			stCopyWrite:
			begin
				memAddr = {yAddr[11:6], count1};
				memWriteEn = 1'b1;
				memData = {16'd0, memReadData[15:0]};
				op = opAdd;
				opA = {26'd0, count1};
				opB = 32'd1;
				nextCount1 = opResult[5:0];
				nextState = stCopyAddr;
			end
			stUpdateCheck:
			begin
				if (memReadData == 32'd1)
					nextState = stUpdateAddr;
				else
				begin
					nextDone = 1'b1;
					nextState = stInit;
				end
			end
			stUpdateAddr:
			begin
				if (count1 >= `SYN_FILT_M)
				begin
					nextDone = 1'b1;
					nextState = stInit;
				end
				else
				begin
					// last M outputs become the new filter memory
					memAddr = {yAddr[11:6], 6'(`SYN_FILT_L - `SYN_FILT_M) + count1};
					nextState = stUpdateWrite;
				end
			end
			stUpdateWrite:
			begin
				memAddr = {fMemAddr[11:6], count1};
				memWriteEn = 1'b1;
				memData = {16'd0, memReadData[15:0]};
				op = opAdd;
				opA = {26'd0, count1};
				opB = 32'd1;
				nextCount1 = opResult[5:0];
				nextState = stUpdateAddr;
			end
			default: nextState = stInit;
		endcase
	end

	// the memory only follows this port while busy
	assert property (@(posedge clk) disable iff (reset) !busy |-> !memWriteEn)
		else $error("memory write while not busy");

	assert property (@(posedge clk) disable iff (reset) shlReady |=> !shlReady)
		else $error("shlReady held for two cycles");

endmodule

// ==== verilog/synthesisFilterCore.sv ====
`timescale 1ns/10ps
`include "synFilt_consts.svh"

module synthesisFilterCore import basicOpPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`ADDR_W-1:0] xAddr,
	input logic [`ADDR_W-1:0] aAddr,
	input logic [`ADDR_W-1:0] yAddr,
	input logic [`ADDR_W-1:0] fMemAddr,
	input logic [`ADDR_W-1:0] updateAddr,
	input logic hostWriteEn,
	input logic [`ADDR_W-1:0] hostAddr,
	input logic [`DATA_W-1:0] hostData,
	output logic done,
	output logic busy,
	output logic [`DATA_W-1:0] hostReadData
);

	// filter port
	logic [`ADDR_W-1:0] memAddr;
	logic memWriteEn;
	logic [`DATA_W-1:0] memData;
	logic [`DATA_W-1:0] memReadData;

	// operator unit
	basicOpcode op;
	logic [`DATA_W-1:0] opA, opB, opC;
	logic [`DATA_W-1:0] opResult;
	logic [`DATA_W-1:0] shlValue;
	logic [15:0] shlAmount;
	logic shlReady;
	logic [`DATA_W-1:0] shlResult;
	logic shlDone;

	synFilt synFilt_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.xAddr(xAddr),
		.aAddr(aAddr),
		.yAddr(yAddr),
		.fMemAddr(fMemAddr),
		.updateAddr(updateAddr),
		.memReadData(memReadData),
		.opResult(opResult),
		.shlResult(shlResult),
		.shlDone(shlDone),
		.done(done),
		.busy(busy),
		.memAddr(memAddr),
		.memWriteEn(memWriteEn),
		.memData(memData),
		.op(op),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.shlValue(shlValue),
		.shlAmount(shlAmount),
		.shlReady(shlReady)
	);

	basicOps basicOps_i
	(
		.clk(clk),
		.reset(reset),
		.op(op),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.shlValue(shlValue),
		.shlAmount(shlAmount),
		.shlReady(shlReady),
		.opResult(opResult),
		.shlResult(shlResult),
		.shlDone(shlDone)
	);

	scratchMemory scratchMemory_i
	(
		.clk(clk),
		.busy(busy),
		.memAddr(memAddr),
		.memWriteEn(memWriteEn),
		.memData(memData),
		.hostWriteEn(hostWriteEn),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.memReadData(memReadData),
		.hostReadData(hostReadData)
	);

endmodule

// ==== tests/synFiltTb.sv ====
`timescale 1ns/10ps
`include "synFilt_consts.svh"

module synFiltTb import synFiltPkg::*;
();

	// trace layout, one block of words per case
	localparam int coefOff = 1;
	localparam int memOff = coefOff + `SYN_FILT_M + 1;
	localparam int xOff = memOff + `SYN_FILT_M;
	localparam int yOff = xOff + `SYN_FILT_L;
	localparam int newMemOff = yOff + `SYN_FILT_L;
	localparam int caseWords = newMemOff + `SYN_FILT_M;
	localparam int maxCases = 8;

	localparam int resetCycles = 5;
	localparam int stateSpan = 1 << $bits(synFiltState);
	// per pass bound, inner loop plus a full state sweep for every sample
	localparam int passCycles = `SYN_FILT_L * (3 * `SYN_FILT_M + stateSpan)
		+ 2 * `SYN_FILT_L + 4 * `SYN_FILT_M + stateSpan;
	// host writes, then two cycles per word read back
	localparam int loadCycles = (2 * `SYN_FILT_M + `SYN_FILT_L + 4)
		+ 3 * (`SYN_FILT_L + `SYN_FILT_M) + 8;

	localparam logic [`ADDR_W-1:0] xBase = 12'h040;
	localparam logic [`ADDR_W-1:0] aBase = 12'h080;
	localparam logic [`ADDR_W-1:0] yBase = 12'h0C0;
	localparam logic [`ADDR_W-1:0] memBase = 12'h100;
	localparam logic [`ADDR_W-1:0] flagAddr = 12'h140;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic hostWriteEn;
	logic [`ADDR_W-1:0] hostAddr;
	logic [`DATA_W-1:0] hostData;
	logic done;
	logic busy;
	logic [`DATA_W-1:0] hostReadData;

	logic [`DATA_W-1:0] trace [0:maxCases*caseWords-1];
	int errorCount = 0;
	int checkCount = 0;
	int startCount = 0;
	int doneCount = 0;
	int cycleCount = 0;
	int cycleLimit = resetCycles + maxCases * (passCycles + loadCycles);
	int caseCount = 0;

	synthesisFilterCore synthesisFilterCore_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.xAddr(xBase),
		.aAddr(aBase),
		.yAddr(yBase),
		.fMemAddr(memBase),
		.updateAddr(flagAddr),
		.hostWriteEn(hostWriteEn),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.done(done),
		.busy(busy),
		.hostReadData(hostReadData)
	);

	always #2 clk = ~clk;

	always @(negedge clk)
	begin
		if (done === 1'b1)
			doneCount++;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout after %0d cycles, the filter never finished", cycleCount);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// host port
	////////////////////////////////////////////////////////////////////////////

	task automatic writeWord(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		@(posedge clk);
		hostWriteEn <= 1'b1;
		hostAddr <= addr;
		hostData <= data;
	endtask

	task automatic finishWrites();
		@(posedge clk);
		hostWriteEn <= 1'b0; // last word lands on this edge
	endtask

	task automatic readWord(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
		@(posedge clk);
		hostAddr <= addr;
		@(posedge clk); // read register loads here
		@(negedge clk);
		data = hostReadData;
	endtask

	task automatic checkWord(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] expected);
		logic [`DATA_W-1:0] actual;
		readWord(addr, actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("ERR %0t: word %03h expected %08h got %08h", $time, addr, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one case of the trace
	////////////////////////////////////////////////////////////////////////////

	task automatic loadCase(input int base);
		logic [`DATA_W-1:0] header;
		header = trace[base];
		for (int j = 0; j <= `SYN_FILT_M; j++)
			writeWord(aBase + 12'(j), trace[base + coefOff + j]);
		if (!header[4]) // bit 4 keeps the memory left by the previous call
		begin
			for (int k = 0; k < `SYN_FILT_M; k++)
				writeWord(memBase + 12'(k), trace[base + memOff + k]);
		end
		for (int n = 0; n < `SYN_FILT_L; n++)
			writeWord(xBase + 12'(n), trace[base + xOff + n]);
		writeWord(flagAddr, {31'd0, header[0]});
		finishWrites();
	endtask

	task automatic runFilter();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		startCount++;
		@(negedge clk);
		while (done !== 1'b1)
			@(negedge clk);
		checkCount++;
		assert (busy === 1'b0)
		else
		begin
			errorCount++;
			$display("ERR %0t: busy %b with done, expected 0", $time, busy);
		end
	endtask

	task automatic checkCase(input int base);
		for (int n = 0; n < `SYN_FILT_L; n++)
			checkWord(yBase + 12'(n), trace[base + yOff + n]);
		for (int k = 0; k < `SYN_FILT_M; k++)
			checkWord(memBase + 12'(k), trace[base + newMemOff + k]);
		checkCount++;
		assert (doneCount == startCount)
		else
		begin
			errorCount++;
			$display("ERR %0t: %0d done pulses for %0d starts", $time, doneCount, startCount);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int base;
		reset = 1'b1;
		start = 1'b0;
		hostWriteEn = 1'b0;
		hostAddr = '0;
		hostData = '0;
		$readmemh("tests/synFiltTrace.txt", trace);
		if ($isunknown(trace[0]) || trace[0][31:16] == 0 || trace[0][31:16] > maxCases)
		begin
			$display("trace file is missing or its header is malformed");
			$display("SOME TESTS FAILED");
			$finish;
		end
		else
		begin
			caseCount = trace[0][31:16];
			cycleLimit = resetCycles + 4 + caseCount * (passCycles + loadCycles);
			repeat (resetCycles) @(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			checkCount++;
			assert (busy === 1'b0 && done === 1'b0)
			else
			begin
				errorCount++;
				$display("ERR %0t: busy %b done %b after reset, expected 0 0", $time, busy, done);
			end
			for (int c = 0; c < caseCount; c++)
			begin
				base = c * caseWords;
				loadCase(base);
				runFilter();
				checkCase(base);
			end
			$display("%0d errors in %0d checks", errorCount, checkCount);
			if (errorCount == 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

// ==== compile.f ====
+incdir+include
verilog/basicOpPkg.sv
verilog/synFiltPkg.sv
verilog/basicOps.sv
verilog/scratchMemory.sv
verilog/synFilt.sv
verilog/synthesisFilterCore.sv
tests/synFiltTb.sv

// ==== tests/synFiltTrace.txt ====
// per case: header {case count, flags: bit 0 update, bit 4 keep memory}, a0..a10,
// mem[0..9], x[0..39], expected y[0..39], expected mem[0..9] after the call
// case 0: y = x + y[n-1] - y[n-10], small values, update on
00030001
1000 F000 0000 0000 0000 0000 0000 0000 0000 0000 1000
0001 0002 0003 0004 0005 0006 0007 0008 0009 000A
0003 0003 0003 0003 0003 0003 0003 0003 0003 0003
0003 0003 0003 0003 0003 0003 0003 0003 0003 0003
0003 0003 0003 0003 0003 0003 0003 0003 0003 0003
0003 0003 0003 0003 0003 0003 0003 0003 0003 0003
000C 000D 000D 000C 000A 0007 0003 FFFE FFF8 FFF1
FFE8 FFDE FFD4 FFCB FFC4 FFC0 FFC0 FFC5 FFD0 FFE2
FFFD 0022 0051 0089 00C8 010B 014E 018C 01BF 01E0
01E6 01C7 0179 00F3 002E FF26 FDDB FC52 FA96 F8B9
01E6 01C7 0179 00F3 002E FF26 FDDB FC52 FA96 F8B9
// case 1: memory carried from case 0, y = x + y[n-10], update off
00030010
1000 0000 0000 0000 0000 0000 0000 0000 0000 0000 F000
01E6 01C7 0179 00F3 002E FF26 FDDB FC52 FA96 F8B9
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
01E7 01C8 017A 00F4 002F FF27 FDDC FC53 FA97 F8BA
01E8 01C9 017B 00F5 0030 FF28 FDDD FC54 FA98 F8BB
01E9 01CA 017C 00F6 0031 FF29 FDDE FC55 FA99 F8BC
01EA 01CB 017D 00F7 0032 FF2A FDDF FC56 FA9A F8BD
01E6 01C7 0179 00F3 002E FF26 FDDB FC52 FA96 F8B9
// case 2: large coefficients, msu and shift saturate, update on
00030001
7FFF 8000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
4000 4000 C000 8000 8000 8000 0000 7FFF 4000 4000
C000 8000 8000 8000 0000 7FFF 4000 4000 C000 8000
8000 8000 0000 7FFF 4000 4000 C000 8000 8000 8000
0000 7FFF 4000 4000 C000 8000 8000 8000 0000 7FFF
7FFF 7FFF 7FFF 0000 8000 8000 8000 FFF0 7FFF 7FFF
7FFF 0000 8000 8000 8000 FFF0 7FFF 7FFF 7FFF 0000
8000 8000 8000 FFF0 7FFF 7FFF 7FFF 0000 8000 8000
8000 FFF0 7FFF 7FFF 7FFF 0000 8000 8000 8000 FFF0
8000 FFF0 7FFF 7FFF 7FFF 0000 8000 8000 8000 FFF0
